// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_vga_sram
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'All tests passed!'

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_vga_sram.sv ====
// zero-delay sram model; run from the project root so bench/vga_cases.txt is found

`timescale 1ns/1ps

module tb_vga_sram import vga_pkg::*; ();

    localparam int H_ACTIVE      = 32;
    localparam int H_FRONT       = 4;
    localparam int H_SYNC        = 6;
    localparam int H_BACK        = 5;
    localparam int V_ACTIVE      = 12;
    localparam int V_FRONT       = 2;
    localparam int V_SYNC        = 2;
    localparam int V_BACK        = 3;
    localparam int MARKER_SIZE   = 3;
    localparam int GRID_STEP     = 4;
    localparam int H_TOTAL       = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL       = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES  = H_TOTAL * V_TOTAL;
    localparam int ACTIVE_PIXELS = H_ACTIVE * V_ACTIVE;
    localparam int WAIT_LIMIT    = 2 * FRAME_CYCLES;
    localparam int MAX_CASES     = 64;

    logic        clk;
    logic        rst_n;
    logic [15:0] position;
    logic        hsync;
    logic        vsync;
    logic        blank_n;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    logic [19:0] sram_addr;
    wire  [15:0] sram_dq;
    logic        sram_we_n;

    int          errors;
    int          timeouts;
    // position in the top 16 bits, then newest, middle, oldest
    logic [63:0] cases [0:MAX_CASES-1];

    vga_sram_top #(
        .H_ACTIVE    (H_ACTIVE),
        .H_FRONT     (H_FRONT),
        .H_SYNC      (H_SYNC),
        .H_BACK      (H_BACK),
        .V_ACTIVE    (V_ACTIVE),
        .V_FRONT     (V_FRONT),
        .V_SYNC      (V_SYNC),
        .V_BACK      (V_BACK),
        .MARKER_SIZE (MARKER_SIZE),
        .GRID_STEP   (GRID_STEP)
    ) dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_position  (position),
        .o_hsync     (hsync),
        .o_vsync     (vsync),
        .o_blank_n   (blank_n),
        .o_red       (red),
        .o_green     (green),
        .o_blue      (blue),
        .o_sram_addr (sram_addr),
        .io_sram_dq  (sram_dq),
        .o_sram_we_n (sram_we_n)
    );

    // sram contents as a fixed hash of the address
    function automatic logic [15:0] model_word(input logic [19:0] addr);
        logic [15:0] prod;
        prod = addr[15:0] * 16'h9e37;
        return prod ^ 16'h1234;
    endfunction

    assign sram_dq = model_word(sram_addr);

    task automatic check_value(input string name, input logic [47:0] got,
                               input logic [47:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // colour of the k-th active pixel of a frame
    function automatic rgb_t expected_rgb(input int k, input pos_history_t hist);
        grid_pos_t g [3];
        int        x;
        int        y;
        int        cx;
        int        cy;
        logic [15:0] word;
        logic [3:0]  code;
        g[0] = hist.newest;
        g[1] = hist.middle;
        g[2] = hist.oldest;
        x = k % H_ACTIVE;
        y = k / H_ACTIVE;
        for (int i = 0; i < 3; i++) begin
            cx = int'(g[i].gx) * GRID_STEP;
            cy = int'(g[i].gy) * GRID_STEP;
            if (x >= cx && x < cx + MARKER_SIZE && y >= cy && y < cy + MARKER_SIZE) begin
                return MARKER_COLOR[i];
            end
        end
        word = model_word(20'(k / 4));
        code = word[4*(k%4) +: 4];
        return BG_PALETTE[code];
    endfunction

    task automatic check_idle(input string when);
        check_value({"o_hsync ", when}, hsync, 1);
        check_value({"o_vsync ", when}, vsync, 1);
        check_value({"o_blank_n ", when}, blank_n, 0);
        check_value({"rgb ", when}, {red, green, blue}, 0);
        check_value({"o_sram_we_n ", when}, sram_we_n, 1);
    endtask

    // waits for the rising edge that ends a vsync pulse
    task automatic wait_frame_start();
        int   n;
        logic prev;
        logic found;
        if (timeouts != 0) return;
        n = 0;
        found = 1'b0;
        prev = vsync;
        while (!found && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
            found = !prev && vsync;
            prev = vsync;
        end
        if (!found) begin
            timeouts++;
            $display("timeout: vsync pulse did not end within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic wait_blank_high();
        int n;
        if (timeouts != 0) return;
        n = 0;
        while (!blank_n && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!blank_n) begin
            timeouts++;
            $display("timeout: no active pixel within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic check_frame(input pos_history_t hist, input int c);
        int k;
        int n;
        if (timeouts != 0) return;
        k = 0;
        n = 0;
        while (k < ACTIVE_PIXELS && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
            if (blank_n) begin
                check_value($sformatf("rgb case %0d x=%0d y=%0d", c, k % H_ACTIVE,
                                      k / H_ACTIVE),
                            {red, green, blue}, expected_rgb(k, hist));
                k++;
            end
        end
        if (k < ACTIVE_PIXELS) begin
            timeouts++;
            $display("timeout: frame of case %0d showed only %0d active pixels", c, k);
        end
    endtask

    // line and frame structure, blanking colour and write enable on every cycle
    task automatic watch_structure();
        logic prev_h;
        logic prev_v;
        logic prev_b;
        logic seen_h;
        int   h_low;
        int   h_period;
        int   v_low;
        int   b_run;
        int   lines;
        prev_h = 1'b1;
        prev_v = 1'b1;
        prev_b = 1'b0;
        seen_h = 1'b0;
        h_low = 0;
        h_period = 0;
        v_low = 0;
        b_run = 0;
        lines = 0;
        forever begin
            @(negedge clk);
            if (!blank_n) begin
                check_value("rgb in blanking", {red, green, blue}, 0);
            end
            check_value("o_sram_we_n", sram_we_n, 1);
            h_period++;
            if (!hsync) h_low++;
            if (!vsync) v_low++;
            if (blank_n) b_run++;
            if (prev_h && !hsync) begin
                if (seen_h) check_value("hsync period", h_period, H_TOTAL);
                seen_h = 1'b1;
                h_period = 0;
            end
            if (!prev_h && hsync) begin
                check_value("hsync pulse width", h_low, H_SYNC);
                h_low = 0;
            end
            if (prev_b && !blank_n) begin
                check_value("o_blank_n run length", b_run, H_ACTIVE);
                b_run = 0;
                lines++;
            end
            if (!prev_v && vsync) begin
                check_value("vsync pulse width", v_low, V_SYNC * H_TOTAL);
                check_value("active lines per frame", lines, V_ACTIVE);
                v_low = 0;
                lines = 0;
            end
            prev_h = hsync;
            prev_v = vsync;
            prev_b = blank_n;
        end
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin : main_sequence
        int n_cases;
        int idle;
        errors = 0;
        timeouts = 0;
        rst_n = 1'b0;
        position = 16'h0000;
        void'($urandom(24));
        for (int i = 0; i < MAX_CASES; i++) begin
            cases[i] = '1;
        end
        $readmemh("bench/vga_cases.txt", cases);
        // an all-ones entry ends the list
        n_cases = 0;
        while (n_cases < MAX_CASES && cases[n_cases] !== '1) begin
            n_cases++;
        end
        if (n_cases == 0) begin
            errors++;
            $display("no cases could be read from bench/vga_cases.txt");
        end

        repeat (3) @(negedge clk);
        check_idle("during reset");
        rst_n = 1'b1;
        @(negedge clk);
        check_idle("after reset");
        fork
            watch_structure();
        join_none

        for (int c = 0; c < n_cases && timeouts == 0; c++) begin
            idle = 1 + int'($urandom % 3);
            repeat (idle) wait_frame_start();
            // change the position on the first active pixel of a frame
            wait_blank_high();
            position = cases[c][63:48];
            wait_frame_start();
            check_frame(pos_history_t'(cases[c][47:0]), c);
        end

        $display("errors: %0d, timeouts: %0d, cases run: %0d", errors, timeouts, n_cases);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== bench/vga_cases.txt ====
// columns: i_position, expected newest, expected middle, expected oldest
// each word holds gx in the upper byte and gy in the lower byte
0102_0102_0000_0000
0301_0301_0102_0000
0301_0301_0102_0000
ffff_0301_0102_0000
0500_0500_0301_0102
0102_0102_0500_0301
0500_0500_0102_0500
0202_0202_0500_0102
0700_0700_0202_0500
0702_0702_0700_0202
ffff_0702_0700_0202
2010_2010_0702_0700
0000_0000_2010_0702

// ==== src/marker_compositor.sv ====
// marker corners are taken modulo 4096 after scaling by the grid step

`timescale 1ns/1ps

module marker_compositor import vga_pkg::*; #(
    parameter int MARKER_SIZE = 60,
    parameter int GRID_STEP   = 50
) (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  pixel_pos_t   i_pos,
    input  logic [3:0]   i_bg_code,
    input  pos_history_t i_history,
    output rgb_t         o_rgb,
    output logic         o_hsync,
    output logic         o_vsync,
    output logic         o_blank_n
);

    logic [2:0] hit;
    rgb_t       rgb_next;
    rgb_t       rgb_q;
    logic       hsync_q;
    logic       vsync_q;
    logic       blank_n_q;

    // square hit test against one remembered position
    function automatic logic in_marker(input pixel_pos_t p, input grid_pos_t g);
        coord_t cx;
        coord_t cy;
        coord_t dx;
        coord_t dy;
        cx = coord_t'(g.gx * GRID_STEP);
        cy = coord_t'(g.gy * GRID_STEP);
        dx = p.x - cx;
        dy = p.y - cy;
        return (p.x >= cx) && (dx < MARKER_SIZE) && (p.y >= cy) && (dy < MARKER_SIZE);
    endfunction

    assign hit[0] = in_marker(i_pos, i_history.newest);
    assign hit[1] = in_marker(i_pos, i_history.middle);
    assign hit[2] = in_marker(i_pos, i_history.oldest);

    // newest marker wins where squares overlap
    always_comb begin
        if (!i_pos.active) begin
            rgb_next = '0;
        end else if (hit[0]) begin
            rgb_next = MARKER_COLOR[0];
        end else if (hit[1]) begin
            rgb_next = MARKER_COLOR[1];
        end else if (hit[2]) begin
            rgb_next = MARKER_COLOR[2];
        end else begin
            rgb_next = BG_PALETTE[i_bg_code];
        end
    end

    // syncs turn active low in the output registers
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rgb_q     <= '0;
            hsync_q   <= 1'b1;
            vsync_q   <= 1'b1;
            blank_n_q <= 1'b0;
        end else begin
            rgb_q     <= rgb_next;
            hsync_q   <= ~i_pos.hsync;
            vsync_q   <= ~i_pos.vsync;
            blank_n_q <= i_pos.active;
        end
    end

    assign o_rgb     = rgb_q;
    assign o_hsync   = hsync_q;
    assign o_vsync   = vsync_q;
    assign o_blank_n = blank_n_q;

endmodule

// ==== src/position_history.sv ====
// input is sampled every cycle as a level; the all-ones word never enters the history

`timescale 1ns/1ps

module position_history import vga_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  grid_pos_t    i_position,
    output pos_history_t o_history
);

    logic         accept;
    pos_history_t history_q;

    // only a changed and valid position shifts in
    assign accept = (i_position != history_q.newest) && (i_position != NO_POSITION);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            history_q <= '0;
        end else if (accept) begin
            history_q.newest <= i_position;
            history_q.middle <= history_q.newest;
            history_q.oldest <= history_q.middle;
        end
    end

    assign o_history = history_q;

endmodule

// ==== src/sram_fetch.sv ====
// sram must return the word within the cycle its address is driven; index holds 22 bits

`timescale 1ns/1ps

module sram_fetch import vga_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  pixel_pos_t  i_pos,
    output logic [19:0] o_sram_addr,
    input  sram_word_t  i_sram_data,
    output pixel_pos_t  o_pos,
    output logic [3:0]  o_bg_code
);

    localparam int IDX_W = 22;

    logic [IDX_W-1:0] pix_idx;
    logic [19:0]      addr_q;
    sram_word_t       data_q;
    pixel_pos_t       pos_d1;
    pixel_pos_t       pos_d2;
    logic [1:0]       sel_d1;
    logic [1:0]       sel_d2;

    // active pixel index within the frame restarts on vsync lines
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pix_idx <= '0;
        end else if (i_pos.vsync) begin
            pix_idx <= '0;
        end else if (i_pos.active) begin
            pix_idx <= pix_idx + 1'b1;
        end
    end

    // four pixels per word
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            addr_q <= '0;
            pos_d1 <= '0;
            pos_d2 <= '0;
        end else begin
            addr_q <= pix_idx[IDX_W-1:2];
            pos_d1 <= i_pos;
            pos_d2 <= pos_d1;
        end
    end

    // word for addr_q is on the bus now
    always_ff @(posedge i_clk) begin
        data_q.raw <= i_sram_data.raw;
        sel_d1     <= pix_idx[1:0];
        sel_d2     <= sel_d1;
    end

    assign o_sram_addr = addr_q;
    assign o_pos       = pos_d2;
    assign o_bg_code   = data_q.code[sel_d2];

endmodule

// ==== src/vga_pkg.sv ====
// palette and marker colours are fixed here; grid corners wrap past 4095 pixels

package vga_pkg;

    // screen coordinate wide enough for 1600x900 plus blanking
    typedef logic [11:0] coord_t;

    // sync flags are high while the generator sits in the sync phase
    typedef struct packed {
        logic   active;
        logic   hsync;
        logic   vsync;
        coord_t x;
        coord_t y;
    } pixel_pos_t;

    // gx is the upper byte of the input word
    typedef struct packed {
        logic [7:0] gx;
        logic [7:0] gy;
    } grid_pos_t;

    typedef struct packed {
        grid_pos_t newest;
        grid_pos_t middle;
        grid_pos_t oldest;
    } pos_history_t;

    // code[0] is the lowest nibble
    typedef union packed {
        logic [15:0]      raw;
        logic [3:0][3:0]  code;
    } sram_word_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // background colour codes
    parameter rgb_t BG_PALETTE [16] = '{
        '{8'h00, 8'h00, 8'h00}, '{8'h10, 8'h30, 8'h10},
        '{8'h20, 8'h50, 8'h20}, '{8'h30, 8'h70, 8'h30},
        '{8'h40, 8'h90, 8'h40}, '{8'h60, 8'hb0, 8'h50},
        '{8'h80, 8'h60, 8'h30}, '{8'ha0, 8'h80, 8'h40},
        '{8'h30, 8'h30, 8'h60}, '{8'h40, 8'h50, 8'h90},
        '{8'h60, 8'h80, 8'hc0}, '{8'h90, 8'h90, 8'h90},
        '{8'hc0, 8'hc0, 8'hc0}, '{8'he0, 8'hd0, 8'ha0},
        '{8'hf0, 8'he8, 8'hd0}, '{8'hff, 8'hff, 8'hff}
    };

    // newest, middle, oldest
    parameter rgb_t MARKER_COLOR [3] = '{
        '{8'hff, 8'h20, 8'h20},
        '{8'hff, 8'hc0, 8'h00},
        '{8'h20, 8'h80, 8'hff}
    };

    parameter grid_pos_t NO_POSITION = '1;

endpackage

// ==== src/vga_sram_top.sv ====
// read-only sram port; all video outputs lag the timing generator by three cycles

`timescale 1ns/1ps

module vga_sram_top import vga_pkg::*; #(
    parameter int H_ACTIVE    = 1600,
    parameter int H_FRONT     = 96,
    parameter int H_SYNC      = 24,
    parameter int H_BACK      = 80,
    parameter int V_ACTIVE    = 900,
    parameter int V_FRONT     = 96,
    parameter int V_SYNC      = 1,
    parameter int V_BACK      = 3,
    parameter int MARKER_SIZE = 60,
    parameter int GRID_STEP   = 50
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic [15:0] i_position,
    output logic        o_hsync,
    output logic        o_vsync,
    output logic        o_blank_n,
    output logic [7:0]  o_red,
    output logic [7:0]  o_green,
    output logic [7:0]  o_blue,
    output logic [19:0] o_sram_addr,
    inout  wire  [15:0] io_sram_dq,
    output logic        o_sram_we_n
);

    pixel_pos_t   gen_pos;
    pixel_pos_t   fetch_pos;
    logic [3:0]   bg_code;
    pos_history_t history;
    rgb_t         rgb;

    // the sram is only read and its data bus stays with the sram
    assign o_sram_we_n = 1'b1;
    assign io_sram_dq  = 'z;

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) u_timing (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .o_pos   (gen_pos)
    );

    position_history u_history (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_position (grid_pos_t'(i_position)),
        .o_history  (history)
    );

    sram_fetch u_fetch (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_pos       (gen_pos),
        .o_sram_addr (o_sram_addr),
        .i_sram_data (sram_word_t'(io_sram_dq)),
        .o_pos       (fetch_pos),
        .o_bg_code   (bg_code)
    );

    marker_compositor #(
        .MARKER_SIZE (MARKER_SIZE),
        .GRID_STEP   (GRID_STEP)
    ) u_compositor (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_pos     (fetch_pos),
        .i_bg_code (bg_code),
        .i_history (history),
        .o_rgb     (rgb),
        .o_hsync   (o_hsync),
        .o_vsync   (o_vsync),
        .o_blank_n (o_blank_n)
    );

    assign o_red   = rgb.r;
    assign o_green = rgb.g;
    assign o_blue  = rgb.b;

endmodule

// ==== src/vga_timing.sv ====
// every phase length must be at least one cycle and fit in twelve bits

`timescale 1ns/1ps

module vga_timing import vga_pkg::*; #(
    parameter int H_ACTIVE = 1600,
    parameter int H_FRONT  = 96,
    parameter int H_SYNC   = 24,
    parameter int H_BACK   = 80,
    parameter int V_ACTIVE = 900,
    parameter int V_FRONT  = 96,
    parameter int V_SYNC   = 1,
    parameter int V_BACK   = 3
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    output pixel_pos_t o_pos
);

    // phase order along a line or a frame
    typedef enum logic [1:0] {
        PH_BACK,
        PH_ACTIVE,
        PH_FRONT,
        PH_SYNC
    } phase_t;

    phase_t h_phase;
    phase_t v_phase;
    coord_t h_cnt;
    coord_t v_cnt;
    logic   h_last;
    logic   v_last;
    logic   line_end;

    // last count value of a phase
    function automatic coord_t phase_last(input phase_t ph, input int back,
                                          input int active, input int front,
                                          input int sync);
        int len;
        case (ph)
            PH_BACK:   len = back;
            PH_ACTIVE: len = active;
            PH_FRONT:  len = front;
            default:   len = sync;
        endcase
        return coord_t'(len - 1);
    endfunction

    function automatic phase_t next_phase(input phase_t ph);
        case (ph)
            PH_BACK:   return PH_ACTIVE;
            PH_ACTIVE: return PH_FRONT;
            PH_FRONT:  return PH_SYNC;
            default:   return PH_BACK;
        endcase
    endfunction

    assign h_last   = (h_cnt == phase_last(h_phase, H_BACK, H_ACTIVE, H_FRONT, H_SYNC));
    assign v_last   = (v_cnt == phase_last(v_phase, V_BACK, V_ACTIVE, V_FRONT, V_SYNC));
    // vertical machine steps at the last sync cycle of each line
    assign line_end = (h_phase == PH_SYNC) && h_last;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            h_phase <= PH_BACK;
            h_cnt   <= '0;
        end else if (h_last) begin
            h_phase <= next_phase(h_phase);
            h_cnt   <= '0;
        end else begin
            h_cnt   <= h_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            v_phase <= PH_BACK;
            v_cnt   <= '0;
        end else if (line_end) begin
            if (v_last) begin
                v_phase <= next_phase(v_phase);
                v_cnt   <= '0;
            end else begin
                v_cnt   <= v_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        o_pos.active = (h_phase == PH_ACTIVE) && (v_phase == PH_ACTIVE);
        o_pos.hsync  = (h_phase == PH_SYNC);
        o_pos.vsync  = (v_phase == PH_SYNC);
        // coordinates are zero outside the active area
        o_pos.x      = (h_phase == PH_ACTIVE) ? h_cnt : '0;
        o_pos.y      = (v_phase == PH_ACTIVE) ? v_cnt : '0;
    end

endmodule

// ==== tb.f ====
src/vga_pkg.sv
src/vga_timing.sv
src/position_history.sv
src/sram_fetch.sv
src/marker_compositor.sv
src/vga_sram_top.sv
bench/tb_vga_sram.sv
